// ==== div_unit_top.f ====
+incdir+include
source/div_pkg.sv
source/div_prep.sv
source/div_iter.sv
source/div_fixup.sv
source/div_unit_top.sv
verif/div_tb_clk.sv
verif/div_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/div_pkg.sv
      - source/div_prep.sv
      - source/div_iter.sv
      - source/div_fixup.sv
      - source/div_unit_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/div_tb_clk.sv
      - verif/div_tb.sv

// ==== verif/div_tb.sv ====
/*
 * testbench for the RV64 divide unit
 * directed and random divisions against an ISA reference model, with
 * latency, back-pressure and ignored request checks
 */

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_tb import div_pkg::*; ();

  localparam int XLEN      = `DIV_XLEN;
  localparam int N_RAND    = 200;
  localparam int MAX_STALL = 6;
  localparam int N_REQ     = N_RAND + 20;             // plus zero divisor, overflow, word
  localparam int TIMEOUT   = N_REQ * 70 + N_REQ * MAX_STALL + 500;

  logic     clk;
  logic     rst_n;
  logic     req_valid_i;
  div_req_t req_i;
  logic     busy_o;
  logic     rsp_valid_o;
  div_rsp_t rsp_o;
  logic     rsp_ready_i;

  integer   seed         = 52105;
  int       errors       = 0;
  int       sent         = 0;
  int       accept_count = 0;
  int       resp_count   = 0;
  int       cycles       = 0;
  bit       in_flight    = 1'b0;
  bit       seen_valid   = 1'b0;
  int       lat;
  int       exp_lat;
  div_rsp_t exp_rsp;
  div_req_t cur_req;                                  // request being checked

  div_tb_clk div_tb_clk_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  div_unit_top div_unit_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i)
  );

  // ==========================================================================
  // reference model and checks
  // ==========================================================================

  // ISA rules, with the zero divisor and overflow results spelled out
  function automatic div_rsp_t expected_result(input div_op_e op, input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b, output int cyc);
    logic            w;
    logic            u;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] res;
    div_rsp_t        rsp;
    w = op[DIV_OP_WORD_BIT];
    u = op[DIV_OP_UNS_BIT];
    x = w ? (u ? {32'h0, a[31:0]} : {{32{a[31]}}, a[31:0]}) : a;
    y = w ? (u ? {32'h0, b[31:0]} : {{32{b[31]}}, b[31:0]}) : b;
    cyc = w ? 33 : 65;
    if (y == '0) begin
      q   = '1;
      r   = x;
      cyc = 1;
    end else if (!u && y == '1 && x == (w ? {{33{1'b1}}, 31'h0} : {1'b1, 63'h0})) begin
      q   = x;                                          // most negative by minus one
      r   = '0;
      cyc = 1;
    end else if (u) begin
      q = x / y;
      r = x % y;
    end else begin
      q = $signed(x) / $signed(y);                      // truncates toward zero
      r = $signed(x) % $signed(y);
    end
    res        = op[DIV_OP_REM_BIT] ? r : q;
    rsp.result = w ? {{32{res[31]}}, res[31:0]} : res;
    return rsp;
  endfunction

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_rsp(input div_rsp_t got, input div_rsp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] rsp_o.result got 0x%h expected 0x%h (op 0x%h a 0x%h b 0x%h)",
                          got.result, exp.result, cur_req.op, cur_req.dividend,
                          cur_req.divisor));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("[ERROR] latency got 0x%h expected 0x%h (op 0x%h)",
                          got, exp, cur_req.op));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ==========================================================================
  // monitor, samples on the rising edge what settled during the low phase
  // ==========================================================================

  always @(posedge clk) begin
    if (rst_n) begin
      in_flight  = 1'b0;
      seen_valid = 1'b0;
    end else if (in_flight) begin
      if (rsp_valid_o) begin
        if (!seen_valid) begin
          check_latency(lat, exp_lat);
          seen_valid = 1'b1;
        end
        check_rsp(rsp_o, exp_rsp);                      // must hold while stalled
        check_flag("busy_o", busy_o, 1'b0);
        if (rsp_ready_i) begin
          in_flight  = 1'b0;
          seen_valid = 1'b0;
          resp_count++;
        end
      end else begin
        if (seen_valid) begin
          abort_run("rsp_valid_o dropped before the response was taken");
        end
        if (lat >= exp_lat) begin
          check_latency(lat + 1, exp_lat);              // response is late
        end
        check_flag("busy_o", busy_o, exp_lat != 1);
      end
      lat++;
    end else begin
      check_flag("rsp_valid_o", rsp_valid_o, 1'b0);     // no stray response
      check_flag("busy_o", busy_o, 1'b0);
      if (req_valid_i) begin
        cur_req   = req_i;
        exp_rsp   = expected_result(req_i.op, req_i.dividend, req_i.divisor, exp_lat);
        lat       = 0;
        in_flight = 1'b1;
        accept_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      abort_run("timeout: the divisions did not finish within the cycle limit");
    end
  end

  // ==========================================================================
  // stimulus, driven on the falling edge
  // ==========================================================================

  function automatic logic [XLEN-1:0] rand_operand();
    logic [XLEN-1:0] v;
    v = {$random(seed), $random(seed)};
    v = v >> ($unsigned($random(seed)) % XLEN);         // vary the magnitude
    if ($random(seed) & 1) begin
      v = -v;
    end
    return v;
  endfunction

  // poke strobes a request while busy or while the result is held
  task automatic run_div(input div_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input int stall, input bit poke);
    int wait_cyc;
    req_i.op       = op;
    req_i.dividend = a;
    req_i.divisor  = b;
    req_valid_i    = 1'b1;
    rsp_ready_i    = (stall == 0);
    sent++;
    @(negedge clk);
    wait_cyc = 0;
    while (!rsp_valid_o) begin
      req_valid_i    = poke && (wait_cyc == 2) && busy_o;
      req_i.dividend = rand_operand();
      @(negedge clk);
      wait_cyc++;
    end
    for (int i = 0; i < stall; i++) begin
      req_valid_i = poke && (i == 0);
      @(negedge clk);
    end
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    @(negedge clk);                                     // response taken
    rsp_ready_i = 1'b0;
  endtask

  initial begin
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    @(negedge clk);
    while (rst_n) begin
      @(negedge clk);
    end
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("rsp_valid_o", rsp_valid_o, 1'b0);

    for (int k = 0; k < 8; k++) begin                   // zero divisor, upper bits set for W
      run_div(div_op_e'(k), rand_operand(), k[0] ? {$random(seed), 32'h0} : '0, 1, 1);
    end
    run_div(DIV_OP_DIV, {1'b1, 63'h0}, '1, 0, 0);
    run_div(DIV_OP_REM, {1'b1, 63'h0}, '1, 2, 1);
    run_div(DIV_OP_DIVW, {$random(seed), 32'h8000_0000}, {$random(seed), 32'hffff_ffff}, 0, 0);
    run_div(DIV_OP_REMW, {$random(seed), 32'h8000_0000}, {$random(seed), 32'hffff_ffff}, 3, 1);
    for (int k = 0; k < 8; k++) begin                   // W ops ignore the upper halves
      run_div(div_op_e'(k | 1), 64'hdead_beef_ffff_fff9, 64'h1234_5678_0000_0002, 0, k[1]);
    end
    for (int n = 0; n < N_RAND; n++) begin
      run_div(div_op_e'($unsigned($random(seed)) % 8), rand_operand(), rand_operand(),
              $unsigned($random(seed)) % (MAX_STALL + 1), $random(seed) & 1);
    end

    repeat (4) @(negedge clk);
    if (accept_count != sent || resp_count != sent) begin
      abort_run("the number of accepted requests or responses does not match the requests sent");
    end
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/div_tb_clk.sv ====
/*
 * testbench clock and reset generator
 * 40 ns clock, reset held high for the first three cycles
 */

`timescale 1ns/1ps
`default_nettype none

module div_tb_clk #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b1;                          // active high reset
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/div_unit_top.sv ====
/*
 * RV64 M extension divide unit
 * single division in flight, start strobe with busy flag, held result
 * released by the consumer's ready
 */

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_unit_top import div_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid_i,
  input  div_req_t req_i,
  output logic     busy_o,
  output logic     rsp_valid_o,
  output div_rsp_t rsp_o,
  input  logic     rsp_ready_i
);

  div_operand_t               operand;   // conditioned request
  div_operand_t               ctx;       // stored context
  logic [2*`DIV_XLEN-1:0]     rem_quo;

  // ==========================================================================
  // operand conditioning
  // ==========================================================================

  div_prep div_prep_inst (
    .req_i     (req_i),
    .operand_o (operand)
  );

  // ==========================================================================
  // control and iteration
  // ==========================================================================

  div_iter div_iter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (req_valid_i),
    .operand_i   (operand),
    .rsp_ready_i (rsp_ready_i),
    .busy_o      (busy_o),
    .done_o      (rsp_valid_o),   // DONE state is the response valid
    .rem_quo_o   (rem_quo),
    .ctx_o       (ctx)
  );

  // ==========================================================================
  // result forming
  // ==========================================================================

  div_fixup div_fixup_inst (
    .rem_quo_i (rem_quo),
    .ctx_i     (ctx),
    .rsp_o     (rsp_o)
  );

endmodule

`default_nettype wire

// ==== source/div_fixup.sv ====
/*
 * divide result forming
 * picks quotient or remainder, restores the sign, sign extends W results
 * and substitutes the bypass result for zero divisor and overflow
 */

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_fixup import div_pkg::*; (
  input  logic [2*`DIV_XLEN-1:0] rem_quo_i,
  input  div_operand_t          ctx_i,
  output div_rsp_t              rsp_o
);

  localparam int XLEN = `DIV_XLEN;
  localparam int WLEN = `DIV_WLEN;

  logic            is_rem;
  logic            is_word;
  logic            neg;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] sel;
  logic [XLEN-1:0] sgn_val;
  logic [XLEN-1:0] word_val;

  assign is_rem  = ctx_i.op[DIV_OP_REM_BIT];
  assign is_word = ctx_i.op[DIV_OP_WORD_BIT];

  assign quo = rem_quo_i[XLEN-1:0];
  assign rem = rem_quo_i[2*XLEN-1:XLEN];

  // ==========================================================================
  // sign restore
  // ==========================================================================

  assign sel     = is_rem ? rem : quo;
  assign neg     = is_rem ? ctx_i.r_neg : ctx_i.q_neg;
  assign sgn_val = neg ? (~sel + 1'b1) : sel;

  // W ops always sign extend bit 31
  assign word_val = {{(XLEN-WLEN){sgn_val[WLEN-1]}}, sgn_val[WLEN-1:0]};

  always_comb begin
    if (ctx_i.bypass) begin
      rsp_o.result = ctx_i.bypass_res;
    end else if (is_word) begin
      rsp_o.result = word_val;
    end else begin
      rsp_o.result = sgn_val;
    end
  end

endmodule

`default_nettype wire

// ==== source/div_iter.sv ====
/*
 * divide control and restoring loop
 * one quotient bit per cycle, holds the division context and the raw
 * remainder and quotient until the consumer takes the result
 */

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_iter import div_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  div_operand_t          operand_i,
  input  logic                  rsp_ready_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic [2*`DIV_XLEN-1:0] rem_quo_o,
  output div_operand_t          ctx_o
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int CNT_W = `DIV_CNT_W;

  div_state_e        state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [2*XLEN-1:0] rem_quo_q;   // remainder high, quotient low
  div_operand_t      ctx_q;
  logic              accept;
  logic              iter_step;
  logic [XLEN:0]     partial;     // 2r plus next dividend bit
  logic [XLEN+1:0]   diff;
  logic              borrow;
  logic [XLEN-1:0]   rem_next;

  assign accept    = start_i && (state_q == DIV_IDLE);
  assign iter_step = (state_q == DIV_ITER) && (cnt_q != '0);

  // ==========================================================================
  // shift and subtract
  // ==========================================================================

  assign partial  = rem_quo_q[2*XLEN-1:XLEN-1];
  assign diff     = {1'b0, partial} - {2'b00, ctx_q.divisor};
  assign borrow   = diff[XLEN+1];
  assign rem_next = borrow ? partial[XLEN-1:0] : diff[XLEN-1:0];   // restore on borrow

  // ==========================================================================
  // control FSM
  // ==========================================================================

  // bypass passes one ITER cycle with zero count and busy masked
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (accept) begin
            state_q <= DIV_ITER;
            cnt_q   <= operand_i.bypass ? '0 : operand_i.iter_cnt;
          end
        end
        DIV_ITER: begin
          if (cnt_q == '0) begin
            state_q <= DIV_DONE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        DIV_DONE: begin
          if (rsp_ready_i) begin
            state_q <= DIV_IDLE;
          end
        end
        default: begin
          state_q <= DIV_IDLE;
        end
      endcase
    end
  end

  // context and working register
  always_ff @(posedge clk) begin
    if (accept) begin
      ctx_q     <= operand_i;
      rem_quo_q <= {{XLEN{1'b0}}, operand_i.dividend};
    end else if (iter_step) begin
      rem_quo_q <= {rem_next, rem_quo_q[XLEN-2:0], ~borrow};   // new quotient bit
    end
  end

  assign busy_o    = (state_q == DIV_ITER) && !ctx_q.bypass;
  assign done_o    = (state_q == DIV_DONE);
  assign rem_quo_o = rem_quo_q;
  assign ctx_o     = ctx_q;

  // ==========================================================================
  // assertions
  // ==========================================================================

  a_busy_done_excl : assert property (@(posedge clk) disable iff (rst_n)
    !(busy_o && done_o));

  // count stays within the loaded length
  a_cnt_no_wrap : assert property (@(posedge clk) disable iff (rst_n)
    (state_q == DIV_ITER) |-> (cnt_q <= ctx_q.iter_cnt));

  // result frozen under back-pressure
  a_done_hold : assert property (@(posedge clk) disable iff (rst_n)
    (done_o && !rsp_ready_i) |=> (done_o && $stable(rem_quo_q) && $stable(ctx_q)));

endmodule

`default_nettype wire

// ==== source/div_prep.sv ====
/*
 * divide operand conditioning
 * word extension, sign capture, absolute values and word pre-shift,
 * plus detection of the zero divisor and signed overflow bypass cases
 */

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_prep import div_pkg::*; (
  input  div_req_t     req_i,
  output div_operand_t operand_o
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int WLEN  = `DIV_WLEN;
  localparam int CNT_W = `DIV_CNT_W;

  logic            is_word;
  logic            is_uns;
  logic            is_rem;
  logic [XLEN-1:0] a_sext32;
  logic [XLEN-1:0] b_sext32;
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;
  logic [XLEN-1:0] min_val;
  logic [XLEN-1:0] a_res;
  logic            div_zero;
  logic            div_ovf;

  assign is_word = req_i.op[DIV_OP_WORD_BIT];
  assign is_uns  = req_i.op[DIV_OP_UNS_BIT];
  assign is_rem  = req_i.op[DIV_OP_REM_BIT];

  // ==========================================================================
  // operand extension and magnitudes
  // ==========================================================================

  assign a_sext32 = {{(XLEN-WLEN){req_i.dividend[WLEN-1]}}, req_i.dividend[WLEN-1:0]};
  assign b_sext32 = {{(XLEN-WLEN){req_i.divisor[WLEN-1]}}, req_i.divisor[WLEN-1:0]};

  always_comb begin
    if (!is_word) begin
      a_ext = req_i.dividend;
      b_ext = req_i.divisor;
    end else if (is_uns) begin
      a_ext = {{(XLEN-WLEN){1'b0}}, req_i.dividend[WLEN-1:0]};
      b_ext = {{(XLEN-WLEN){1'b0}}, req_i.divisor[WLEN-1:0]};
    end else begin
      a_ext = a_sext32;
      b_ext = b_sext32;
    end
  end

  assign a_neg = !is_uns && a_ext[XLEN-1];
  assign b_neg = !is_uns && b_ext[XLEN-1];
  assign a_abs = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 1'b1) : b_ext;

  // ==========================================================================
  // bypass detection
  // ==========================================================================

  // most negative value, already sign extended for W ops
  assign min_val = is_word ? {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}}
                           : {1'b1, {(XLEN-1){1'b0}}};

  assign div_zero = (b_ext == '0);                      // low word only for W ops
  assign div_ovf  = !is_uns && (a_ext == min_val) && (&b_ext);

  assign a_res = is_word ? a_sext32 : req_i.dividend;   // dividend as a result value

  always_comb begin
    operand_o.op       = req_i.op;
    operand_o.dividend = is_word ? {a_abs[WLEN-1:0], {(XLEN-WLEN){1'b0}}} : a_abs;
    operand_o.divisor  = b_abs;
    operand_o.iter_cnt = is_word ? CNT_W'(WLEN) : CNT_W'(XLEN);
    operand_o.q_neg    = a_neg ^ b_neg;
    operand_o.r_neg    = a_neg;                          // remainder follows dividend
    operand_o.bypass   = div_zero || div_ovf;
    if (div_zero) begin
      operand_o.bypass_res = is_rem ? a_res : {XLEN{1'b1}};
    end else if (div_ovf) begin
      operand_o.bypass_res = is_rem ? '0 : a_res;
    end else begin
      operand_o.bypass_res = '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/div_pkg.sv ====
/*
 * divide unit types
 * operation and state encodings, request, conditioned operand and response
 */

`default_nettype none

`include "div_config.svh"

package div_pkg;

  // op bit positions
  localparam int unsigned DIV_OP_WORD_BIT = 0;
  localparam int unsigned DIV_OP_UNS_BIT  = 1;
  localparam int unsigned DIV_OP_REM_BIT  = 2;

  typedef enum logic [3:0] {
    DIV_OP_DIV   = 4'b0000,
    DIV_OP_DIVW  = 4'b0001,
    DIV_OP_DIVU  = 4'b0010,
    DIV_OP_DIVUW = 4'b0011,
    DIV_OP_REM   = 4'b0100,
    DIV_OP_REMW  = 4'b0101,
    DIV_OP_REMU  = 4'b0110,
    DIV_OP_REMUW = 4'b0111
  } div_op_e;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'b00,
    DIV_ITER = 2'b01,
    DIV_DONE = 2'b10
  } div_state_e;

  typedef struct packed {
    div_op_e              op;
    logic [`DIV_XLEN-1:0] dividend;   // rs1
    logic [`DIV_XLEN-1:0] divisor;    // rs2
  } div_req_t;

  typedef struct packed {
    div_op_e               op;
    logic [`DIV_XLEN-1:0]  dividend;    // magnitude, pre-shifted for W ops
    logic [`DIV_XLEN-1:0]  divisor;     // magnitude
    logic [`DIV_CNT_W-1:0] iter_cnt;    // 64 or 32
    logic                  q_neg;       // negate quotient at the end
    logic                  r_neg;       // negate remainder at the end
    logic                  bypass;      // zero divisor or overflow
    logic [`DIV_XLEN-1:0]  bypass_res;  // ISA defined result
  } div_operand_t;

  typedef struct packed {
    logic [`DIV_XLEN-1:0] result;
  } div_rsp_t;

endpackage

`default_nettype wire

// ==== include/div_config.svh ====
/*
 * divide unit configuration
 * data width, word width for the W operations and iteration counter width
 */

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// ==========================================================================
// datapath widths
// ==========================================================================

`define DIV_XLEN 64   // full register width
`define DIV_WLEN 32   // operand width of the W operations

// ==========================================================================
// iteration control
// ==========================================================================

// must hold the value DIV_XLEN itself
`define DIV_CNT_W 7

`endif
